/* include/regblk_settings.svh */
`ifndef REGBLK_SETTINGS_SVH
`define REGBLK_SETTINGS_SVH

// bus widths
`define REGBLK_ADDR_W 16
`define REGBLK_DATA_W 32
`define REGBLK_STRB_W 4

// address map, the block decodes word addresses above base
`define REGBLK_BASE_ADDR 16'h1000
`define REGBLK_CTRL_OFS 16'h0000
`define REGBLK_STATUS_OFS 16'h0004
`define REGBLK_TRIG_OFS 16'h0008
`define REGBLK_EVENT_OFS 16'h000C

// reset and default values
`define REGBLK_CTRL_RESET 32'h0000_01C3
`define REGBLK_DEFAULT_RDATA 32'hDEAD_BEAF

// number of event flags in the EVENT register
`define REGBLK_EVENT_W 4

`endif

/* hdl/regblk_pkg.sv */
`include "regblk_settings.svh"

package regblk_pkg;

  typedef enum logic [1:0] {
    OKAY   = 2'b00,
    SLVERR = 2'b10
  } axi_resp_e;

  typedef enum logic [1:0] {
    IDLE,
    WRITE_RESP,
    READ_RESP
  } fe_state_e;

  typedef enum logic {
    ACCESS_READ,
    ACCESS_WRITE
  } access_kind_e;

  typedef struct packed {
    logic                      awvalid;
    logic [`REGBLK_ADDR_W-1:0] awaddr;
    logic                      wvalid;
    logic [`REGBLK_DATA_W-1:0] wdata;
    logic [`REGBLK_STRB_W-1:0] wstrb;
    logic                      bready;
    logic                      arvalid;
    logic [`REGBLK_ADDR_W-1:0] araddr;
    logic                      rready;
  } axi_req_t;

  typedef struct packed {
    logic                      awready;
    logic                      wready;
    logic                      bvalid;
    axi_resp_e                 bresp;
    logic                      arready;
    logic                      rvalid;
    logic [`REGBLK_DATA_W-1:0] rdata;
    axi_resp_e                 rresp;
  } axi_rsp_t;

  typedef struct packed {
    logic                      valid;
    access_kind_e              kind;
    logic [`REGBLK_ADDR_W-1:0] addr;
    logic [`REGBLK_DATA_W-1:0] wdata;
    logic [`REGBLK_STRB_W-1:0] strb;
  } reg_access_t;

  // field order matches the CTRL register layout, enable is bit 8
  typedef struct packed {
    logic       enable;
    logic [3:0] gain;
    logic [3:0] mode;
  } ctrl_fields_t;

  typedef struct packed {
    logic [3:0] stop;
    logic [3:0] start;
  } trigger_t;

endpackage

/* hdl/event_status_reg.sv */
`timescale 1ns/1ps
`include "regblk_settings.svh"

module event_status_reg #(
  parameter int W = `REGBLK_EVENT_W
) (
  input  logic         clk,
  input  logic         i_rst,
  input  logic [W-1:0] i_set,
  input  logic [W-1:0] i_clear,
  input  logic         i_enable_we,
  input  logic [W-1:0] i_enable_wdata,
  output logic [W-1:0] o_flags,
  output logic [W-1:0] o_enable,
  output logic         o_irq
);

  logic [W-1:0] flags_q;
  logic [W-1:0] enable_q;
  logic         irq_q;

  always_ff @(posedge clk) begin
    if (i_rst) begin
      flags_q  <= '0;
      enable_q <= '0;
      irq_q    <= 1'b0;
    end else begin
      flags_q <= i_set | (flags_q & ~i_clear); // a set pulse beats a clear in the same cycle
      if (i_enable_we) begin
        enable_q <= i_enable_wdata;
      end
      irq_q <= |(flags_q & enable_q);
    end
  end

  assign o_flags  = flags_q;
  assign o_enable = enable_q;
  assign o_irq    = irq_q;

endmodule

/* hdl/register_file.sv */
`timescale 1ns/1ps
`include "regblk_settings.svh"

module register_file (
  input  logic                      clk,
  input  logic                      i_rst,
  input  regblk_pkg::reg_access_t   i_access,
  output logic [`REGBLK_DATA_W-1:0] o_rdata,
  output logic                      o_error,
  input  logic [15:0]               i_status,
  input  logic [`REGBLK_EVENT_W-1:0] i_event_set,
  output regblk_pkg::ctrl_fields_t  o_ctrl,
  output regblk_pkg::trigger_t      o_trigger,
  output logic                      o_irq
);

  localparam int AW = `REGBLK_ADDR_W;
  localparam int DW = `REGBLK_DATA_W;
  localparam int EW = `REGBLK_EVENT_W;
  localparam int CW = $bits(regblk_pkg::ctrl_fields_t);

  localparam logic [AW-1:0] CTRL_ADDR   = `REGBLK_BASE_ADDR + `REGBLK_CTRL_OFS;
  localparam logic [AW-1:0] STATUS_ADDR = `REGBLK_BASE_ADDR + `REGBLK_STATUS_OFS;
  localparam logic [AW-1:0] TRIG_ADDR   = `REGBLK_BASE_ADDR + `REGBLK_TRIG_OFS;
  localparam logic [AW-1:0] EVENT_ADDR  = `REGBLK_BASE_ADDR + `REGBLK_EVENT_OFS;
  localparam logic [DW-1:0] CTRL_RESET  = `REGBLK_CTRL_RESET;

  logic                     hit_ctrl;
  logic                     hit_status;
  logic                     hit_trig;
  logic                     hit_event;
  logic                     wr_en;
  regblk_pkg::ctrl_fields_t ctrl_q;
  regblk_pkg::trigger_t     trigger_q;
  logic [EW-1:0]            event_clear;
  logic                     event_enable_we;
  logic [EW-1:0]            event_flags;
  logic [EW-1:0]            event_enable;

  // byte offset bits are ignored, registers are matched by word address
  assign hit_ctrl   = (i_access.addr[AW-1:2] == CTRL_ADDR[AW-1:2]);
  assign hit_status = (i_access.addr[AW-1:2] == STATUS_ADDR[AW-1:2]);
  assign hit_trig   = (i_access.addr[AW-1:2] == TRIG_ADDR[AW-1:2]);
  assign hit_event  = (i_access.addr[AW-1:2] == EVENT_ADDR[AW-1:2]);

  assign wr_en = i_access.valid && (i_access.kind == regblk_pkg::ACCESS_WRITE);

  always_ff @(posedge clk) begin
    if (i_rst) begin
      ctrl_q <= CTRL_RESET[CW-1:0];
    end else if (wr_en && hit_ctrl) begin
      if (i_access.strb[0]) begin
        ctrl_q.mode <= i_access.wdata[3:0];
        ctrl_q.gain <= i_access.wdata[7:4];
      end
      if (i_access.strb[1]) begin
        ctrl_q.enable <= i_access.wdata[8];
      end
    end
  end

  // every written one becomes a single cycle pulse
  always_ff @(posedge clk) begin
    if (i_rst) begin
      trigger_q <= '0;
    end else if (wr_en && hit_trig && i_access.strb[0]) begin
      trigger_q <= i_access.wdata[7:0];
    end else begin
      trigger_q <= '0;
    end
  end

  assign event_clear     = (wr_en && hit_event && i_access.strb[0]) ?
                           i_access.wdata[EW-1:0] : '0;
  assign event_enable_we = wr_en && hit_event && i_access.strb[1];

  event_status_reg #(
    .W (EW)
  ) u_event (
    .clk            (clk),
    .i_rst          (i_rst),
    .i_set          (i_event_set),
    .i_clear        (event_clear),
    .i_enable_we    (event_enable_we),
    .i_enable_wdata (i_access.wdata[8 +: EW]),
    .o_flags        (event_flags),
    .o_enable       (event_enable),
    .o_irq          (o_irq)
  );

  always_comb begin
    o_rdata = '0;
    o_error = 1'b0;
    if (hit_ctrl) begin
      o_rdata[CW-1:0] = ctrl_q;
    end else if (hit_status) begin
      o_rdata[15:0] = i_status; // writes here fall through with OKAY
    end else if (hit_trig) begin
      o_rdata = '0;
    end else if (hit_event) begin
      o_rdata[EW-1:0]  = event_flags;
      o_rdata[8 +: EW] = event_enable;
    end else begin
      o_rdata = `REGBLK_DEFAULT_RDATA;
      o_error = 1'b1;
    end
  end

  assign o_ctrl    = ctrl_q;
  assign o_trigger = trigger_q;

endmodule

/* hdl/axi4lite_frontend.sv */
`timescale 1ns/1ps
`include "regblk_settings.svh"

module axi4lite_frontend (
  input  logic                      clk,
  input  logic                      i_rst,
  input  regblk_pkg::axi_req_t      i_axi_req,
  output regblk_pkg::axi_rsp_t      o_axi_rsp,
  output regblk_pkg::reg_access_t   o_access,
  input  logic [`REGBLK_DATA_W-1:0] i_rdata,
  input  logic                      i_error
);

  regblk_pkg::fe_state_e     state;
  regblk_pkg::fe_state_e     state_next;
  logic                      wr_accept;
  logic                      rd_accept;
  regblk_pkg::axi_resp_e     bresp_q;
  regblk_pkg::axi_resp_e     rresp_q;
  logic [`REGBLK_DATA_W-1:0] rdata_q;

  // a write needs both address and data, and it wins over a read
  assign wr_accept = (state == regblk_pkg::IDLE) && i_axi_req.awvalid && i_axi_req.wvalid;
  assign rd_accept = (state == regblk_pkg::IDLE) && i_axi_req.arvalid && !wr_accept;

  always_comb begin
    o_access.valid = wr_accept || rd_accept;
    if (wr_accept) begin
      o_access.kind = regblk_pkg::ACCESS_WRITE;
      o_access.addr = i_axi_req.awaddr;
      o_access.strb = i_axi_req.wstrb;
    end else begin
      o_access.kind = regblk_pkg::ACCESS_READ;
      o_access.addr = i_axi_req.araddr;
      o_access.strb = '0; // reads touch no byte lanes
    end
    o_access.wdata = i_axi_req.wdata;
  end

  always_comb begin
    state_next = state;
    case (state)
      regblk_pkg::IDLE: begin
        if (wr_accept) begin
          state_next = regblk_pkg::WRITE_RESP;
        end else if (rd_accept) begin
          state_next = regblk_pkg::READ_RESP;
        end
      end
      regblk_pkg::WRITE_RESP: begin
        if (i_axi_req.bready) begin
          state_next = regblk_pkg::IDLE;
        end
      end
      regblk_pkg::READ_RESP: begin
        if (i_axi_req.rready) begin
          state_next = regblk_pkg::IDLE;
        end
      end
      default: begin
        state_next = regblk_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      state <= regblk_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  // responses are captured once at acceptance and then held until the handshake
  always_ff @(posedge clk) begin
    if (wr_accept) begin
      bresp_q <= i_error ? regblk_pkg::SLVERR : regblk_pkg::OKAY;
    end
    if (rd_accept) begin
      rresp_q <= i_error ? regblk_pkg::SLVERR : regblk_pkg::OKAY;
      rdata_q <= i_rdata;
    end
  end

  always_comb begin
    o_axi_rsp.awready = wr_accept;
    o_axi_rsp.wready  = wr_accept;
    o_axi_rsp.arready = rd_accept;
    o_axi_rsp.bvalid  = (state == regblk_pkg::WRITE_RESP);
    o_axi_rsp.bresp   = bresp_q;
    o_axi_rsp.rvalid  = (state == regblk_pkg::READ_RESP);
    o_axi_rsp.rdata   = rdata_q;
    o_axi_rsp.rresp   = rresp_q;
  end

endmodule

/* hdl/regblk_top.sv */
`timescale 1ns/1ps
`include "regblk_settings.svh"

module regblk_top (
  input  logic                       clk,
  input  logic                       i_rst,
  input  regblk_pkg::axi_req_t       i_axi_req,
  output regblk_pkg::axi_rsp_t       o_axi_rsp,
  input  logic [15:0]                i_status,
  input  logic [`REGBLK_EVENT_W-1:0] i_event_set,
  output regblk_pkg::ctrl_fields_t   o_ctrl,
  output regblk_pkg::trigger_t       o_trigger,
  output logic                       o_irq
);

  regblk_pkg::reg_access_t   access;
  logic [`REGBLK_DATA_W-1:0] rdata;
  logic                      error;

  axi4lite_frontend u_frontend (
    .clk       (clk),
    .i_rst     (i_rst),
    .i_axi_req (i_axi_req),
    .o_axi_rsp (o_axi_rsp),
    .o_access  (access),
    .i_rdata   (rdata),
    .i_error   (error)
  );

  register_file u_regs (
    .clk         (clk),
    .i_rst       (i_rst),
    .i_access    (access),
    .o_rdata     (rdata),
    .o_error     (error),
    .i_status    (i_status),
    .i_event_set (i_event_set),
    .o_ctrl      (o_ctrl),
    .o_trigger   (o_trigger),
    .o_irq       (o_irq)
  );

endmodule

/* test/regblk_checker.sv */
`timescale 1ns/1ps

module regblk_checker (
  input logic                 clk,
  input logic                 i_rst,
  input regblk_pkg::axi_req_t i_req,
  input regblk_pkg::axi_rsp_t i_rsp,
  input regblk_pkg::trigger_t i_trigger
);

  bresp_held : assert property (@(posedge clk) disable iff (i_rst)
    i_rsp.bvalid && !i_req.bready |=> i_rsp.bvalid && $stable(i_rsp.bresp))
    else $error("bvalid dropped or bresp changed before bready");

  rdata_held : assert property (@(posedge clk) disable iff (i_rst)
    i_rsp.rvalid && !i_req.rready |=>
      i_rsp.rvalid && $stable(i_rsp.rdata) && $stable(i_rsp.rresp))
    else $error("rvalid dropped or read data changed before rready");

  // bvalid or rvalid high means the front end is out of IDLE
  ready_in_idle : assert property (@(posedge clk) disable iff (i_rst)
    (i_rsp.awready || i_rsp.wready || i_rsp.arready) |-> !i_rsp.bvalid && !i_rsp.rvalid)
    else $error("a ready signal is high while a response is pending");

  trigger_pulse : assert property (@(posedge clk) disable iff (i_rst)
    (i_trigger != '0) |=> (i_trigger == '0))
    else $error("trigger output stayed high for more than one cycle");

endmodule

bind regblk_top regblk_checker u_checker (
  .clk       (clk),
  .i_rst     (i_rst),
  .i_req     (i_axi_req),
  .i_rsp     (o_axi_rsp),
  .i_trigger (o_trigger)
);

/* test/regblk_tb.sv */
`timescale 1ns/1ps
`include "regblk_settings.svh"

module regblk_tb;

  localparam int TIMEOUT = 50;
  localparam logic [15:0] CTRL_A   = `REGBLK_BASE_ADDR + `REGBLK_CTRL_OFS;
  localparam logic [15:0] STATUS_A = `REGBLK_BASE_ADDR + `REGBLK_STATUS_OFS;
  localparam logic [15:0] TRIG_A   = `REGBLK_BASE_ADDR + `REGBLK_TRIG_OFS;
  localparam logic [15:0] EVENT_A  = `REGBLK_BASE_ADDR + `REGBLK_EVENT_OFS;
  localparam logic [31:0] CTRL_RST = `REGBLK_CTRL_RESET;

  logic                     clk;
  logic                     rst;
  regblk_pkg::axi_req_t     axi_req;
  regblk_pkg::axi_rsp_t     axi_rsp;
  logic [15:0]              status;
  logic [3:0]               event_set;
  regblk_pkg::ctrl_fields_t ctrl;
  regblk_pkg::trigger_t     trigger;
  logic                     irq;

  integer      seed;
  int          errors;
  int          checks;
  int          tests_run;
  int          errors_at_start;
  string       test_name;
  logic [8:0]  model_ctrl;
  logic [3:0]  model_flags;
  logic [3:0]  model_enable;
  logic [7:0]  first_trigger;
  logic [33:0] exp_rdata[$]; // {rresp, rdata} per pending read
  logic [1:0]  exp_bresp[$];

  regblk_top UUT (
    .clk         (clk),
    .i_rst       (rst),
    .i_axi_req   (axi_req),
    .o_axi_rsp   (axi_rsp),
    .i_status    (status),
    .i_event_set (event_set),
    .o_ctrl      (ctrl),
    .o_trigger   (trigger),
    .o_irq       (irq)
  );

  always #10 clk = ~clk;

  function automatic logic is_mapped(input logic [15:0] addr);
    return addr == CTRL_A || addr == STATUS_A || addr == TRIG_A || addr == EVENT_A;
  endfunction

  function automatic logic [1:0] expected_write_resp(input logic [15:0] addr);
    return is_mapped(addr) ? regblk_pkg::OKAY : regblk_pkg::SLVERR;
  endfunction

  // expected {resp, data} of a read, taken from the register model
  function automatic logic [33:0] expected_read(input logic [15:0] addr);
    if (addr == CTRL_A) return {regblk_pkg::OKAY, 23'd0, model_ctrl};
    if (addr == STATUS_A) return {regblk_pkg::OKAY, 16'd0, status};
    if (addr == TRIG_A) return {regblk_pkg::OKAY, 32'd0};
    if (addr == EVENT_A) return {regblk_pkg::OKAY, 20'd0, model_enable, 4'd0, model_flags};
    return {regblk_pkg::SLVERR, 32'hDEAD_BEAF};
  endfunction

  task automatic model_write(input logic [15:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    if (addr == CTRL_A) begin
      if (strb[0]) model_ctrl[7:0] = data[7:0]; // mode and gain
      if (strb[1]) model_ctrl[8] = data[8];
    end else if (addr == EVENT_A) begin
      if (strb[0]) model_flags = model_flags & ~data[3:0];
      if (strb[1]) model_enable = data[11:8];
    end
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("FAILED %s expected 0x%0h actual 0x%0h", name, expected, actual);
    end
  endtask

  task automatic hang_abort(input string channel);
    $display("timeout: no handshake on the %s", channel);
    $display("** FAIL **");
    $finish;
  endtask

  task automatic axi_write(input logic [15:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    int n;
    exp_bresp.push_back(expected_write_resp(addr));
    @(posedge clk);
    axi_req.awvalid <= 1'b1;
    axi_req.awaddr  <= addr;
    axi_req.wvalid  <= 1'b1;
    axi_req.wdata   <= data;
    axi_req.wstrb   <= strb;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!axi_rsp.awready && n < TIMEOUT);
    if (!axi_rsp.awready) hang_abort("write address channel");
    if (!axi_rsp.wready) hang_abort("write data channel");
    @(posedge clk); // acceptance edge
    axi_req.awvalid <= 1'b0;
    axi_req.wvalid  <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n == 1) first_trigger = trigger;
    end while (!axi_rsp.bvalid && n < TIMEOUT);
    if (!axi_rsp.bvalid) hang_abort("write response channel");
    @(posedge clk);
    axi_req.bready <= 1'b1; // the response waits one cycle under back-pressure
    @(posedge clk);
    axi_req.bready <= 1'b0;
    model_write(addr, data, strb);
  endtask

  task automatic axi_read(input logic [15:0] addr);
    int n;
    @(posedge clk);
    exp_rdata.push_back(expected_read(addr));
    axi_req.arvalid <= 1'b1;
    axi_req.araddr  <= addr;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!axi_rsp.arready && n < TIMEOUT);
    if (!axi_rsp.arready) hang_abort("read address channel");
    @(posedge clk);
    axi_req.arvalid <= 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!axi_rsp.rvalid && n < TIMEOUT);
    if (!axi_rsp.rvalid) hang_abort("read data channel");
    @(posedge clk);
    axi_req.rready <= 1'b1; // read data is held one cycle before rready
    @(posedge clk);
    axi_req.rready <= 1'b0;
  endtask

  task automatic wait_irq(input logic level, input string name);
    int n;
    n = 0;
    while (irq !== level && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    check_value(name, 64'(level), 64'(irq));
  endtask

  task automatic begin_test(input string name);
    test_name = name;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests_run++;
    $display("test %s finished with %0d errors", test_name, errors - errors_at_start);
  endtask

  // every response seen on the bus is compared with the reference
  always @(negedge clk) begin
    logic [33:0] exp_r;
    if (!rst && axi_rsp.rvalid && axi_req.rready) begin
      if (exp_rdata.size() == 0) begin
        errors++;
        $display("read response arrived with no read pending in %s", test_name);
      end else begin
        exp_r = exp_rdata.pop_front();
        check_value({test_name, " read"}, 64'(exp_r), 64'({axi_rsp.rresp, axi_rsp.rdata}));
      end
    end
    if (!rst && axi_rsp.bvalid && axi_req.bready) begin
      if (exp_bresp.size() == 0) begin
        errors++;
        $display("write response arrived with no write pending in %s", test_name);
      end else begin
        check_value({test_name, " bresp"}, 64'(exp_bresp.pop_front()), 64'(axi_rsp.bresp));
      end
    end
  end

  initial begin
    logic [31:0] rnd;
    logic [31:0] data;
    clk = 1'b0;
    rst = 1'b1;
    axi_req = '0;
    status = '0;
    event_set = '0;
    seed = 86;
    model_ctrl = CTRL_RST[8:0];
    model_flags = '0;
    model_enable = '0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;

    begin_test("reset_values");
    axi_read(CTRL_A);
    axi_read(EVENT_A);
    check_value("reset o_ctrl", 64'(CTRL_RST[8:0]), 64'(ctrl));
    check_value("reset o_irq", 64'd0, 64'(irq));
    check_value("reset o_trigger", 64'd0, 64'(trigger));
    end_test();

    begin_test("ctrl_read_write");
    repeat (20) begin
      data = $random(seed);
      rnd = $random(seed);
      axi_write(CTRL_A, data, rnd[3:0]);
      axi_read(CTRL_A);
      check_value("ctrl o_ctrl", 64'(model_ctrl), 64'(ctrl));
    end
    end_test();

    begin_test("status");
    rnd = $random(seed);
    @(posedge clk);
    status <= rnd[15:0];
    axi_read(STATUS_A);
    data = $random(seed);
    axi_write(STATUS_A, data, 4'hF); // read only, no effect
    axi_read(STATUS_A);
    axi_read(CTRL_A);
    end_test();

    begin_test("trigger");
    rnd = $random(seed);
    axi_write(TRIG_A, {24'd0, rnd[7:0]}, 4'hF);
    check_value("trigger pulse", 64'(rnd[7:0]), 64'(first_trigger));
    @(negedge clk);
    check_value("trigger after pulse", 64'd0, 64'(trigger));
    axi_read(TRIG_A);
    end_test();

    begin_test("events_irq");
    @(posedge clk);
    event_set <= 4'b0101;
    @(posedge clk);
    event_set <= 4'b0000;
    model_flags = model_flags | 4'b0101;
    axi_read(EVENT_A);
    repeat (3) @(negedge clk);
    check_value("irq without enable", 64'd0, 64'(irq));
    axi_write(EVENT_A, 32'h0000_0400, 4'b0010); // enable flag 2 only
    wait_irq(1'b1, "irq after enable");
    axi_write(EVENT_A, 32'h0000_0004, 4'b0001); // clear flag 2
    wait_irq(1'b0, "irq after clear");
    axi_read(EVENT_A);
    end_test();

    begin_test("unmapped");
    axi_read(`REGBLK_BASE_ADDR + 16'h0010);
    axi_read(16'h2000);
    data = $random(seed);
    axi_write(`REGBLK_BASE_ADDR + 16'h0010, data, 4'hF);
    axi_write(16'h0000, data, 4'hF);
    axi_read(CTRL_A);
    end_test();

    repeat (2) @(negedge clk);
    if (exp_rdata.size() != 0 || exp_bresp.size() != 0) begin
      errors++;
      $display("some responses never arrived");
    end
    $display("tests: %0d  checks: %0d  errors: %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+include
hdl/regblk_pkg.sv
hdl/event_status_reg.sv
hdl/register_file.sv
hdl/axi4lite_frontend.sv
hdl/regblk_top.sv
test/regblk_checker.sv
test/regblk_tb.sv

/* run.sh */
#!/bin/sh
# builds the regblk testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --timescale 1ns/1ps \
  --top-module regblk_tb \
  -f all.f

./obj_dir/Vregblk_tb | tee sim.log

if grep -qxF '** PASS **' sim.log; then
  exit 0
fi
echo "simulation did not report a pass, see sim.log"
exit 1
